// ==== design/count_pkg.sv ====
// Counting and arithmetic definitions shared by the divider, counters and ALU
package count_pkg;

    ////////////////////////////////////////
    // BCD digits
    ////////////////////////////////////////

    typedef logic [3:0] bcd_digit_t;       // One decimal digit, 0 to 9
    typedef logic [7:0] alu_result_t;      // Full width ALU output

    localparam int bcd_max = 9;            // Largest legal digit value

    ////////////////////////////////////////
    // Step rate select
    ////////////////////////////////////////

    typedef logic [4:0] rate_sel_t;        // Five speed switches

    // clk cycles per unit of rate select, kept small for short runs
    localparam int tick_base_count = 4;

    // Longest period is (max sel + 1) * base, i.e. 2**5 * base
    localparam int rate_period_max = (2 ** $bits(rate_sel_t)) * tick_base_count;

    // Divider count holds period - 1, so this width is enough
    typedef logic [$clog2(rate_period_max)-1:0] tick_count_t;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////

    // Encoding matches the two op switches directly
    typedef enum logic [1:0] {
        op_add = 2'b00,                    // a + b
        op_sub = 2'b01,                    // a - b, two's complement
        op_and = 2'b10,                    // Bitwise and
        op_or  = 2'b11                     // Bitwise or
    } alu_op_t;

endpackage

// ==== design/display_pkg.sv ====
// Seven-segment display definitions for the scanner and top level
package display_pkg;

    ////////////////////////////////////////
    // Digit and anode lines
    ////////////////////////////////////////

    localparam int digit_count = 3;                // Positions on the display

    typedef logic [3:0]             hex_digit_t;   // Value shown on one position
    typedef logic [digit_count-1:0] anode_t;       // One line per position, active low

    // Exactly one anode low at a time
    localparam anode_t an_pos0 = 3'b110;           // Result low nibble
    localparam anode_t an_pos1 = 3'b101;           // Result high nibble
    localparam anode_t an_pos2 = 3'b011;           // Control switches

    ////////////////////////////////////////
    // Segment patterns
    ////////////////////////////////////////

    // Cathodes active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg_pattern_t;

    // Hex decode, indexed by the digit value
    localparam seg_pattern_t hex_seg_table [16] = '{
        7'h40,  // 0
        7'h79,  // 1
        7'h24,  // 2
        7'h30,  // 3
        7'h19,  // 4
        7'h12,  // 5
        7'h02,  // 6
        7'h78,  // 7
        7'h00,  // 8
        7'h10,  // 9
        7'h08,  // A
        7'h03,  // b
        7'h46,  // C
        7'h21,  // d
        7'h06,  // E
        7'h0E   // F
    };

    ////////////////////////////////////////
    // Scan timing
    ////////////////////////////////////////

    localparam int scan_hold_count = 8;    // clk cycles each position stays lit

    typedef logic [$clog2(scan_hold_count)-1:0] scan_hold_t;

endpackage

// ==== design/rate_divider.sv ====
`timescale 1ns/1ns

// Step tick generator
// Emits a one-cycle enable every (sel + 1) * tick_base_count clk cycles
module rate_divider (
    input  logic                 clk,
    input  logic                 reset,
    input  count_pkg::rate_sel_t sel,          // Speed switches
    output logic                 step_tick     // One-cycle enable pulse
);

    import count_pkg::*;

    tick_count_t reload_value;                 // Period - 1 for the current sel
    tick_count_t tick_count;                   // Cycles left until the next tick

    ////////////////////////////////////////
    // Period from the speed switches
    ////////////////////////////////////////

    // Widen sel before the multiply so the product cannot overflow
    assign reload_value = tick_count_t'((int'(sel) + 1) * tick_base_count - 1);

    ////////////////////////////////////////
    // Down counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_count <= reload_value;        // Count starts fresh once reset drops
        end else if (tick_count == '0) begin
            tick_count <= reload_value;        // New sel only picked up here
        end else begin
            tick_count <= tick_count - 1'b1;
        end
    end

    // Tick on the last cycle of each period
    assign step_tick = (tick_count == '0);

endmodule

// ==== design/bcd_digit_counter.sv ====
`timescale 1ns/1ns

// Single BCD digit, stepping up or down on each tick
module bcd_digit_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  step_tick,   // Advance enable from the divider
    input  logic                  down,        // 1 counts down, 0 counts up
    output count_pkg::bcd_digit_t digit
);

    import count_pkg::*;

    bcd_digit_t next_digit;                    // Value after one step

    ////////////////////////////////////////
    // Step logic with 9/0 wrap
    ////////////////////////////////////////

    always_comb begin
        if (down) begin
            if (digit == '0) begin
                next_digit = bcd_digit_t'(bcd_max);    // 0 wraps to 9
            end else begin
                next_digit = digit - 1'b1;
            end
        end else begin
            if (digit == bcd_digit_t'(bcd_max)) begin
                next_digit = '0;                       // 9 wraps to 0
            end else begin
                next_digit = digit + 1'b1;
            end
        end
    end

    // Holds between ticks
    always_ff @(posedge clk) begin
        if (reset) begin
            digit <= '0;
        end else if (step_tick) begin
            digit <= next_digit;               // Visible the cycle after the tick
        end
    end

endmodule

// ==== design/digit_alu.sv ====
`timescale 1ns/1ns

// Combines two BCD digits into an 8-bit result
// Purely combinational, follows its inputs in the same cycle
module digit_alu (
    input  count_pkg::bcd_digit_t  a,          // Units digit
    input  count_pkg::bcd_digit_t  b,          // Tens digit
    input  count_pkg::alu_op_t     op,
    output count_pkg::alu_result_t result
);

    import count_pkg::*;

    alu_result_t a_ext;                        // Operands widened to result size
    alu_result_t b_ext;

    // Zero extension, so subtraction wraps as 8-bit two's complement
    assign a_ext = alu_result_t'(a);
    assign b_ext = alu_result_t'(b);

    always_comb begin
        case (op)
            op_add:  result = a_ext + b_ext;   // At most 18
            op_sub:  result = a_ext - b_ext;   // 2 - 7 gives 8'hFB
            op_and:  result = a_ext & b_ext;
            op_or:   result = a_ext | b_ext;
            default: result = '0;
        endcase
    end

endmodule

// ==== design/seg7_scanner.sv ====
`timescale 1ns/1ns

// Three-position seven-segment scanner
// Cycles through the positions and drives the shared cathode lines
module seg7_scanner (
    input  logic                      clk,
    input  logic                      reset,
    input  display_pkg::hex_digit_t   digit0,  // Shown while an is 110
    input  display_pkg::hex_digit_t   digit1,  // Shown while an is 101
    input  display_pkg::hex_digit_t   digit2,  // Shown while an is 011
    output display_pkg::seg_pattern_t seg,     // Active low cathodes
    output display_pkg::anode_t       an       // Active low anodes
);

    import display_pkg::*;

    typedef enum logic [1:0] {
        scan_d0,                               // Position 0
        scan_d1,                               // Position 1
        scan_d2                                // Position 2
    } scan_state_t;

    scan_state_t state;                        // Position currently on the lines
    scan_state_t next_state;                   // Position after this one
    scan_state_t upcoming_state;               // Position for the next cycle
    scan_hold_t  hold_count;                   // Cycles spent on this position
    logic        hold_done;                    // Last cycle of this position
    hex_digit_t  upcoming_digit;
    anode_t      upcoming_anode;

    ////////////////////////////////////////
    // Position sequencing
    ////////////////////////////////////////

    assign hold_done = (hold_count == scan_hold_t'(scan_hold_count - 1));

    always_comb begin
        case (state)
            scan_d0: next_state = scan_d1;
            scan_d1: next_state = scan_d2;
            scan_d2: next_state = scan_d0;
            default: next_state = scan_d0;     // Unused code falls back to start
        endcase
    end

    assign upcoming_state = hold_done ? next_state : state;

    // Digit and anode for the position loaded at the next edge
    always_comb begin
        case (upcoming_state)
            scan_d1: begin
                upcoming_digit = digit1;
                upcoming_anode = an_pos1;
            end
            scan_d2: begin
                upcoming_digit = digit2;
                upcoming_anode = an_pos2;
            end
            default: begin
                upcoming_digit = digit0;
                upcoming_anode = an_pos0;
            end
        endcase
    end

    ////////////////////////////////////////
    // State, hold counter and outputs
    ////////////////////////////////////////

    // seg, an and state all move on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= scan_d0;
            hold_count <= '0;
            an         <= an_pos0;
            seg        <= hex_seg_table[digit0];   // Live digit 0 while in reset
        end else begin
            state      <= upcoming_state;
            hold_count <= hold_done ? '0 : hold_count + 1'b1;
            an         <= upcoming_anode;
            seg        <= hex_seg_table[upcoming_digit];
        end
    end

endmodule

// ==== design/counter_display_top.sv ====
`timescale 1ns/1ns

// Two-digit BCD counter with ALU and seven-segment display
//   sw[4:0]  step rate
//   sw[6:5]  ALU operation
//   sw[7]    units direction, sw[8] tens direction
module counter_display_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                [8:0] sw,     // Board switches
    output logic                [7:0] led,    // Tens over units
    output display_pkg::seg_pattern_t seg,
    output display_pkg::anode_t       an
);

    import count_pkg::*;
    import display_pkg::*;

    logic        step_tick;                    // Shared advance enable
    bcd_digit_t  units_digit;
    bcd_digit_t  tens_digit;
    alu_op_t     alu_op;
    alu_result_t alu_result;
    hex_digit_t  result_lo;                    // Display position 0
    hex_digit_t  result_hi;                    // Display position 1
    hex_digit_t  ctrl_nibble;                  // Display position 2

    ////////////////////////////////////////
    // Switch slicing
    ////////////////////////////////////////

    assign alu_op      = alu_op_t'(sw[6:5]);
    assign ctrl_nibble = sw[8:5];              // Op and both direction switches

    ////////////////////////////////////////
    // Counting path
    ////////////////////////////////////////

    rate_divider rate_divider_i (
        .clk       (clk),
        .reset     (reset),
        .sel       (sw[4:0]),
        .step_tick (step_tick)
    );

    bcd_digit_counter units_counter_i (
        .clk       (clk),
        .reset     (reset),
        .step_tick (step_tick),
        .down      (sw[7]),
        .digit     (units_digit)
    );

    // Tens steps on the same tick, no carry from units
    bcd_digit_counter tens_counter_i (
        .clk       (clk),
        .reset     (reset),
        .step_tick (step_tick),
        .down      (sw[8]),
        .digit     (tens_digit)
    );

    digit_alu digit_alu_i (
        .a      (units_digit),
        .b      (tens_digit),
        .op     (alu_op),
        .result (alu_result)
    );

    ////////////////////////////////////////
    // Display path
    ////////////////////////////////////////

    assign result_lo = alu_result[3:0];
    assign result_hi = alu_result[7:4];

    seg7_scanner seg7_scanner_i (
        .clk    (clk),
        .reset  (reset),
        .digit0 (result_lo),
        .digit1 (result_hi),
        .digit2 (ctrl_nibble),
        .seg    (seg),
        .an     (an)
    );

    assign led = {tens_digit, units_digit};    // led[7:4] tens, led[3:0] units

endmodule

// ==== sim/counter_display_assertions.sv ====
`timescale 1ns/1ns

// Concurrent checks on the counter display top level, attached by bind
module counter_display_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                [8:0] sw,
    input logic                [7:0] led,
    input display_pkg::seg_pattern_t seg,
    input display_pkg::anode_t       an
);

    import count_pkg::*;

    localparam int settle_cycles = 32 * tick_base_count;   // Longest step period

    // Lit segments g down to a for 0 to F, the pins themselves are active low
    localparam logic [6:0] seg_lit [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic [8:0] sw_q;                          // Inputs and outputs one cycle back
    logic [7:0] led_q;
    logic [2:0] an_q;
    logic [7:0] gap_count;                     // Cycles since units last moved
    logic [8:0] sel_age;                       // Cycles since sw[4:0] last changed
    logic [7:0] exp_led;
    logic [7:0] exp_result;                    // ALU rule on last cycle's digits
    logic [6:0] exp_seg;
    logic [2:0] exp_an;
    int         step_period;

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////

    function automatic logic [3:0] bcd_step(input logic [3:0] d, input logic down);
        if (down) begin
            return (d == 4'd0) ? 4'd9 : d - 4'd1;   // 0 wraps to 9
        end
        return (d == 4'd9) ? 4'd0 : d + 4'd1;       // 9 wraps to 0
    endfunction

    function automatic logic [7:0] alu_rule(input logic [7:0] digits, input logic [1:0] op);
        logic [7:0] a;
        logic [7:0] b;
        a = {4'h0, digits[3:0]};               // Units
        b = {4'h0, digits[7:4]};               // Tens
        case (op)
            2'b00:   return a + b;
            2'b01:   return a - b;             // Wraps below zero
            2'b10:   return a & b;
            default: return a | b;
        endcase
    endfunction

    // Past values and interval tracking
    always @(posedge clk) begin
        sw_q  <= sw;
        led_q <= led;
        an_q  <= an;
        if (reset || led[3:0] != led_q[3:0]) begin
            gap_count <= 8'd1;
        end else if (gap_count != 8'hFF) begin
            gap_count <= gap_count + 8'd1;     // Saturates
        end
        if (reset || sw[4:0] != sw_q[4:0]) begin
            sel_age <= '0;
        end else if (sel_age != 9'h1FF) begin
            sel_age <= sel_age + 9'd1;
        end
    end

    assign exp_led     = {bcd_step(led_q[7:4], sw_q[8]), bcd_step(led_q[3:0], sw_q[7])};
    assign exp_result  = alu_rule(led_q, sw_q[6:5]);
    assign exp_an      = {an_q[1:0], an_q[2]};          // 110, 101, 011, 110
    assign step_period = (int'(sw_q[4:0]) + 1) * tick_base_count;

    always_comb begin
        case (an)
            3'b110:  exp_seg = ~seg_lit[exp_result[3:0]];
            3'b101:  exp_seg = ~seg_lit[exp_result[7:4]];
            default: exp_seg = ~seg_lit[sw_q[8:5]];     // Control switches
        endcase
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    led_step_a: assert property (@(posedge clk) disable iff (reset)
        led != led_q |-> led == exp_led)
        else begin
            $error("mismatch led_step expected %h actual %h",
                $sampled(exp_led), $sampled(led));
            counter_display_tb.mismatch_count++;
        end

    bcd_range_a: assert property (@(posedge clk) disable iff (reset)
        led[3:0] <= 4'd9 && led[7:4] <= 4'd9)
        else begin
            $error("LED digits left the range 0 to 9, led is %h", $sampled(led));
            counter_display_tb.other_count++;
        end

    an_onehot_a: assert property (@(posedge clk) disable iff (reset) $onehot(~an))
        else begin
            $error("Anode lines do not have exactly one low bit, an is %b", $sampled(an));
            counter_display_tb.other_count++;
        end

    an_order_a: assert property (@(posedge clk) disable iff (reset)
        an != an_q |-> an == exp_an)
        else begin
            $error("mismatch an_order expected %b actual %b", $sampled(exp_an), $sampled(an));
            counter_display_tb.mismatch_count++;
        end

    // Digit shown matches the position lit by an
    seg_value_a: assert property (@(posedge clk) disable iff (reset) seg == exp_seg)
        else begin
            $error("mismatch seg_value expected %h actual %h",
                $sampled(exp_seg), $sampled(seg));
            counter_display_tb.mismatch_count++;
        end

    // Only once sel has been steady for a full extra period
    step_interval_a: assert property (@(posedge clk) disable iff (reset)
        led[3:0] != led_q[3:0] && int'(sel_age) >= int'(gap_count) + settle_cycles
        |-> int'(gap_count) % step_period == 0)
        else begin
            $error("Units step came after %0d cycles, not a multiple of %0d",
                $sampled(gap_count), $sampled(step_period));
            counter_display_tb.other_count++;
        end

endmodule

// ==== sim/counter_display_tb.sv ====
`timescale 1ns/1ns

module counter_display_tb;

    import count_pkg::*;

    localparam int clk_period    = 40;
    localparam int phase_count   = 6;
    localparam int margin_cycles = 200;        // Slack beyond the planned run

    // Lit segments g down to a for 0 to F
    localparam logic [6:0] seg_lit [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic       clk   = 1'b0;
    logic       reset = 1'b1;
    logic [8:0] sw    = '0;
    logic [7:0] led;
    logic [6:0] seg;
    logic [2:0] an;

    int         mismatch_count = 0;            // Also raised by the bound checks
    int         other_count    = 0;
    integer     seed           = 32'haad808d4;
    logic [8:0] phase_sw  [phase_count];       // {tens down, units down, op, sel}
    int         phase_len [phase_count];       // Cycles each setting is held
    int         total_cycles   = 0;
    logic       phases_ready   = 1'b0;

    counter_display_top counter_display_top_i (
        .clk   (clk),
        .reset (reset),
        .sw    (sw),
        .led   (led),
        .seg   (seg),
        .an    (an)
    );

    bind counter_display_top counter_display_assertions assertions_i (
        .clk   (clk),
        .reset (reset),
        .sw    (sw),
        .led   (led),
        .seg   (seg),
        .an    (an)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic build_phases();
        phase_sw[0] = {1'b0, 1'b0, 2'b00, 5'd1};       // Add, both up
        phase_sw[1] = {1'b1, 1'b0, 2'b01, 5'd3};       // Subtract, tens down so it goes negative
        phase_sw[2] = {1'b0, 1'b1, 2'b10, 5'd0};       // And, units down
        phase_sw[3] = {1'b1, 1'b1, 2'b11, 5'd2};       // Or, both down
        for (int i = 4; i < phase_count; i++) begin
            phase_sw[i] = 9'($random(seed));
        end
        for (int i = 0; i < phase_count; i++) begin
            // Divider settle time, then four full step periods
            phase_len[i] = 256 + 4 * (int'(phase_sw[i][4:0]) + 1) * tick_base_count;
            total_cycles += phase_len[i];
        end
    endtask

    // State straight after reset, all ops give 0 on zero digits
    task automatic check_reset_state();
        assert (led == 8'h00) else begin
            $error("mismatch reset_led expected %h actual %h", 8'h00, led);
            mismatch_count++;
        end
        assert (an == 3'b110) else begin
            $error("mismatch reset_an expected %b actual %b", 3'b110, an);
            mismatch_count++;
        end
        assert (seg == ~seg_lit[0]) else begin
            $error("mismatch reset_seg expected %h actual %h", ~seg_lit[0], seg);
            mismatch_count++;
        end
    endtask

    initial begin
        build_phases();
        phases_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);                        // Outputs settled
        check_reset_state();
        for (int i = 0; i < phase_count; i++) begin
            @(posedge clk);
            sw <= phase_sw[i];
            repeat (phase_len[i] - 1) @(posedge clk);
        end
        $display("Checks done: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        wait (phases_ready);
        #((longint'(total_cycles) + 4 + margin_cycles) * clk_period);
        $display("Timeout: run did not end within %0d cycles", total_cycles + 4 + margin_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/count_pkg.sv
design/display_pkg.sv
design/rate_divider.sv
design/bcd_digit_counter.sv
design/digit_alu.sv
design/seg7_scanner.sv
design/counter_display_top.sv
sim/counter_display_assertions.sv
sim/counter_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the counter display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module counter_display_tb \
    -f filelist.f

sim_output=$(./obj_dir/Vcounter_display_tb +verilator+error+limit+1000 2>&1)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx 'Test passed'; then
    exit 0
fi
exit 1
